// File: logic/bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// bus width, both data and instruction side
`define WORD_WIDTH 32

// region bases
// code memory decodes only its low index bits, base kept for reference
`define CODE_BASE 32'h0040_0000
`define DATA_BASE 32'h1001_0000

// memory depths in words
`define CODE_DEPTH 1024
`define DATA_DEPTH 1024

// memory-mapped peripherals
`define STOPWATCH_ADDR 32'hFF20_0510
`define LFSR_ADDR 32'hFF20_0514
`define DISPLAY_ADDR 32'hFF20_0518

// lfsr seed after reset or after a zero write
`define LFSR_RESET_SEED 32'h0000_0001
// galois feedback mask
`define LFSR_TAPS 32'h8020_0003

// clocks per millisecond at 50 MHz
`define STOPWATCH_TICK_CYCLES 50000

`endif

// File: logic/busPkg.sv
`include "bus_defs.svh"

package busPkg;

    // one bus word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // one enable per byte lane
    typedef logic [`WORD_WIDTH/8-1:0] byteEnable_t;

    // active-low segments, bit 0 is a, bit 6 is g
    typedef logic [6:0] segments_t;

    // which peer answered the last data-bus read
    typedef enum logic [2:0] {
        peerNone,
        peerMemory,
        peerStopwatch,
        peerLfsr,
        peerDisplay
    } peerSel_t;

endpackage

// File: logic/wordMemory.sv
module wordMemory #(
    parameter int DEPTH = 1024
) (
    input  logic                CLK,
    input  logic                readEnable,
    input  logic                writeEnable,
    input  busPkg::byteEnable_t byteEnable,
    input  busPkg::word_t       address,
    input  busPkg::word_t       writeData,
    output busPkg::word_t       readData
);

    localparam int indexWidth = $clog2(DEPTH);
    localparam int laneCount = $bits(busPkg::byteEnable_t);

    // storage, no reset
    busPkg::word_t mem [DEPTH];

    logic [indexWidth-1:0] wordIndex;

    // drop byte offset, wrap at depth
    // upper address bits alias
    assign wordIndex = indexWidth'((address >> 2) % DEPTH);

    // per-lane write
    always_ff @(posedge CLK) begin
        for (int lane = 0; lane < laneCount; lane++) begin
            if (writeEnable && byteEnable[lane]) begin
                mem[wordIndex][lane*8 +: 8] <= writeData[lane*8 +: 8];
            end
        end
    end

    // registered read
    // same-cycle write is not visible yet, old word comes out
    // holds the last word between reads
    always_ff @(posedge CLK) begin
        if (readEnable) begin
            readData <= mem[wordIndex];
        end
    end

endmodule

// File: logic/dataBusFabric.sv
`include "bus_defs.svh"

module dataBusFabric (
    input  logic          CLK,
    input  logic          rst,
    input  logic          readEnable,
    input  logic          writeEnable,
    input  busPkg::word_t address,
    output logic          memRead,
    output logic          memWrite,
    output logic          swRead,
    output logic          swWrite,
    output logic          lfsrRead,
    output logic          lfsrWrite,
    output logic          dispRead,
    output logic          dispWrite,
    input  busPkg::word_t memData,
    input  busPkg::word_t swData,
    input  busPkg::word_t lfsrData,
    input  busPkg::word_t dispData,
    output busPkg::word_t readData
);

    // end of data region, exclusive
    localparam busPkg::word_t dataLimit = busPkg::word_t'(`DATA_BASE + `DATA_DEPTH * 4);

    logic memHit;
    logic swHit;
    logic lfsrHit;
    logic dispHit;

    busPkg::peerSel_t selQ;

    // address compare
    assign memHit = (address >= `DATA_BASE) && (address < dataLimit);
    assign swHit = (address == `STOPWATCH_ADDR);
    assign lfsrHit = (address == `LFSR_ADDR);
    assign dispHit = (address == `DISPLAY_ADDR);

    // per-peer strobes
    assign memRead = readEnable && memHit;
    assign memWrite = writeEnable && memHit;
    assign swRead = readEnable && swHit;
    assign swWrite = writeEnable && swHit;
    assign lfsrRead = readEnable && lfsrHit;
    assign lfsrWrite = writeEnable && lfsrHit;
    assign dispRead = readEnable && dispHit;
    assign dispWrite = writeEnable && dispHit;

    // remember who answers next cycle
    // idle or unmapped falls back to none
    always_ff @(posedge CLK) begin
        if (rst) begin
            selQ <= busPkg::peerNone;
        end else if (memRead) begin
            selQ <= busPkg::peerMemory;
        end else if (swRead) begin
            selQ <= busPkg::peerStopwatch;
        end else if (lfsrRead) begin
            selQ <= busPkg::peerLfsr;
        end else if (dispRead) begin
            selQ <= busPkg::peerDisplay;
        end else begin
            selQ <= busPkg::peerNone;
        end
    end

    // read mux over registered peer data
    always_comb begin
        case (selQ)
            busPkg::peerMemory:    readData = memData;
            busPkg::peerStopwatch: readData = swData;
            busPkg::peerLfsr:      readData = lfsrData;
            busPkg::peerDisplay:   readData = dispData;
            default:               readData = '0;
        endcase
    end

endmodule

// File: logic/stopwatchCounter.sv
module stopwatchCounter #(
    parameter int TICK_CYCLES = 50000
) (
    input  logic          CLK,
    input  logic          rst,
    input  logic          read,
    input  logic          write,
    output busPkg::word_t readData
);

    localparam int prescaleWidth = $clog2(TICK_CYCLES + 1);

    logic [prescaleWidth-1:0] prescaler;
    busPkg::word_t            count;
    logic                     tick;

    // last cycle of one millisecond
    assign tick = (prescaler == prescaleWidth'(TICK_CYCLES - 1));

    // prescaler and ms count
    // any write restarts both, data lanes ignored
    always_ff @(posedge CLK) begin
        if (rst || write) begin
            prescaler <= '0;
            count <= '0;
        end else if (tick) begin
            prescaler <= '0;
            count <= count + 1'b1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // sample count on read
    always_ff @(posedge CLK) begin
        if (read) begin
            readData <= count;
        end
    end

endmodule

// File: logic/lfsrGenerator.sv
`include "bus_defs.svh"

module lfsrGenerator (
    input  logic          CLK,
    input  logic          rst,
    input  logic          read,
    input  logic          write,
    input  busPkg::word_t writeData,
    output busPkg::word_t readData
);

    busPkg::word_t state;
    busPkg::word_t nextState;

    // one galois step
    // shift right, fold taps in when the dropped bit was set
    assign nextState = (state >> 1) ^ (state[0] ? `LFSR_TAPS : '0);

    // seed load beats the advance
    // zero would lock the register, so it maps to the reset seed
    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= `LFSR_RESET_SEED;
        end else if (write) begin
            state <= (writeData == '0) ? `LFSR_RESET_SEED : writeData;
        end else if (read) begin
            state <= nextState;
        end
    end

    // value before the step
    always_ff @(posedge CLK) begin
        if (read) begin
            readData <= state;
        end
    end

endmodule

// File: logic/hexDisplay.sv
module hexDisplay (
    input  logic                CLK,
    input  logic                rst,
    input  logic                read,
    input  logic                write,
    input  busPkg::byteEnable_t byteEnable,
    input  busPkg::word_t       writeData,
    output busPkg::word_t       readData,
    output busPkg::segments_t   HEX0,
    output busPkg::segments_t   HEX1,
    output busPkg::segments_t   HEX2,
    output busPkg::segments_t   HEX3,
    output busPkg::segments_t   HEX4,
    output busPkg::segments_t   HEX5
);

    localparam int laneCount = $bits(busPkg::byteEnable_t);

    busPkg::word_t displayReg;

    // hex digit to active-low segments, g is bit 6
    function automatic busPkg::segments_t segmentsOf(input logic [3:0] digit);
        case (digit)
            4'h0: segmentsOf = 7'b1000000;
            4'h1: segmentsOf = 7'b1111001;
            4'h2: segmentsOf = 7'b0100100;
            4'h3: segmentsOf = 7'b0110000;
            4'h4: segmentsOf = 7'b0011001;
            4'h5: segmentsOf = 7'b0010010;
            4'h6: segmentsOf = 7'b0000010;
            4'h7: segmentsOf = 7'b1111000;
            4'h8: segmentsOf = 7'b0000000;
            4'h9: segmentsOf = 7'b0010000;
            4'hA: segmentsOf = 7'b0001000;
            4'hB: segmentsOf = 7'b0000011;
            4'hC: segmentsOf = 7'b1000110;
            4'hD: segmentsOf = 7'b0100001;
            4'hE: segmentsOf = 7'b0000110;
            default: segmentsOf = 7'b0001110;
        endcase
    endfunction

    // byte-writable register
    always_ff @(posedge CLK) begin
        if (rst) begin
            displayReg <= '0;
        end else if (write) begin
            for (int lane = 0; lane < laneCount; lane++) begin
                if (byteEnable[lane]) begin
                    displayReg[lane*8 +: 8] <= writeData[lane*8 +: 8];
                end
            end
        end
    end

    // readback
    always_ff @(posedge CLK) begin
        if (read) begin
            readData <= displayReg;
        end
    end

    // low six nibbles, HEX0 is the lowest
    // top byte is storage only
    assign HEX0 = segmentsOf(displayReg[3:0]);
    assign HEX1 = segmentsOf(displayReg[7:4]);
    assign HEX2 = segmentsOf(displayReg[11:8]);
    assign HEX3 = segmentsOf(displayReg[15:12]);
    assign HEX4 = segmentsOf(displayReg[19:16]);
    assign HEX5 = segmentsOf(displayReg[23:20]);

endmodule

// File: logic/deviceBus.sv
`include "bus_defs.svh"

module deviceBus #(
    parameter int TICK_CYCLES = `STOPWATCH_TICK_CYCLES
) (
    input  logic                CLK,
    input  logic                rst,
    // instruction bus
    input  logic                iReadEnable,
    input  logic                iWriteEnable,
    input  busPkg::byteEnable_t iByteEnable,
    input  busPkg::word_t       iAddress,
    input  busPkg::word_t       iWriteData,
    output busPkg::word_t       iReadData,
    // data bus
    input  logic                dReadEnable,
    input  logic                dWriteEnable,
    input  busPkg::byteEnable_t dByteEnable,
    input  busPkg::word_t       dAddress,
    input  busPkg::word_t       dWriteData,
    output busPkg::word_t       dReadData,
    // seven-segment digits
    output busPkg::segments_t   HEX0,
    output busPkg::segments_t   HEX1,
    output busPkg::segments_t   HEX2,
    output busPkg::segments_t   HEX3,
    output busPkg::segments_t   HEX4,
    output busPkg::segments_t   HEX5
);

    // peer strobes from the decoder
    logic memRead;
    logic memWrite;
    logic swRead;
    logic swWrite;
    logic lfsrRead;
    logic lfsrWrite;
    logic dispRead;
    logic dispWrite;

    // registered read data of each peer
    busPkg::word_t memData;
    busPkg::word_t swData;
    busPkg::word_t lfsrData;
    busPkg::word_t dispData;

    // code side, straight onto the instruction bus
    wordMemory #(
        .DEPTH(`CODE_DEPTH)
    ) codeMemory (
        .CLK        (CLK),
        .readEnable (iReadEnable),
        .writeEnable(iWriteEnable),
        .byteEnable (iByteEnable),
        .address    (iAddress),
        .writeData  (iWriteData),
        .readData   (iReadData)
    );

    wordMemory #(
        .DEPTH(`DATA_DEPTH)
    ) dataMemory (
        .CLK        (CLK),
        .readEnable (memRead),
        .writeEnable(memWrite),
        .byteEnable (dByteEnable),
        .address    (dAddress),
        .writeData  (dWriteData),
        .readData   (memData)
    );

    // decode and read mux
    dataBusFabric fabric (
        .CLK        (CLK),
        .rst        (rst),
        .readEnable (dReadEnable),
        .writeEnable(dWriteEnable),
        .address    (dAddress),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .swRead     (swRead),
        .swWrite    (swWrite),
        .lfsrRead   (lfsrRead),
        .lfsrWrite  (lfsrWrite),
        .dispRead   (dispRead),
        .dispWrite  (dispWrite),
        .memData    (memData),
        .swData     (swData),
        .lfsrData   (lfsrData),
        .dispData   (dispData),
        .readData   (dReadData)
    );

    stopwatchCounter #(
        .TICK_CYCLES(TICK_CYCLES)
    ) stopwatch (
        .CLK     (CLK),
        .rst     (rst),
        .read    (swRead),
        .write   (swWrite),
        .readData(swData)
    );

    lfsrGenerator lfsr (
        .CLK      (CLK),
        .rst      (rst),
        .read     (lfsrRead),
        .write    (lfsrWrite),
        .writeData(dWriteData),
        .readData (lfsrData)
    );

    hexDisplay display (
        .CLK       (CLK),
        .rst       (rst),
        .read      (dispRead),
        .write     (dispWrite),
        .byteEnable(dByteEnable),
        .writeData (dWriteData),
        .readData  (dispData),
        .HEX0      (HEX0),
        .HEX1      (HEX1),
        .HEX2      (HEX2),
        .HEX3      (HEX3),
        .HEX4      (HEX4),
        .HEX5      (HEX5)
    );

endmodule

// File: tests/deviceBus_assert.sv
`include "bus_defs.svh"

module deviceBus_assert (
    input logic                CLK,
    input logic                rst,
    input logic                iReadEnable,
    input logic                iWriteEnable,
    input busPkg::byteEnable_t iByteEnable,
    input busPkg::word_t       iAddress,
    input busPkg::word_t       iWriteData,
    input busPkg::word_t       iReadData,
    input logic                dReadEnable,
    input logic                dWriteEnable,
    input busPkg::byteEnable_t dByteEnable,
    input busPkg::word_t       dAddress,
    input busPkg::word_t       dWriteData,
    input busPkg::word_t       dReadData,
    input busPkg::segments_t   HEX0,
    input busPkg::segments_t   HEX1,
    input busPkg::segments_t   HEX2,
    input busPkg::segments_t   HEX3,
    input busPkg::segments_t   HEX4,
    input busPkg::segments_t   HEX5
);

    // active-low segment patterns by hex digit
    localparam logic [6:0] segTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    // shadow models
    busPkg::word_t dataShadow [1024];
    logic          dataKnown [1024] = '{default: 1'b0};
    busPkg::word_t codeShadow [1024];
    logic          codeKnown [1024] = '{default: 1'b0};
    busPkg::word_t dispShadow;
    busPkg::word_t lfsrShadow;

    // stopwatch bookkeeping
    // clearCycle is the first cycle with a cleared count
    int unsigned cyc = 0;
    int unsigned clearCycle = 0;
    busPkg::word_t swLast;
    busPkg::word_t swBound;
    busPkg::word_t swNow;

    // expected responses for the next cycle
    busPkg::word_t dExp;
    logic          dCheck = 1'b0;
    logic          swCheck = 1'b0;
    busPkg::word_t iExp;
    logic          iCheck = 1'b0;

    // failed assertions so far
    int failCount = 0;

    logic inData;
    logic swHit;
    logic lfsrHit;
    logic dispHit;

    function automatic busPkg::word_t merge(input busPkg::word_t oldWord,
                                            input busPkg::word_t newWord,
                                            input busPkg::byteEnable_t be);
        busPkg::word_t result;
        result = oldWord;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                result[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    // shift right and xor the taps when bit 0 falls out
    function automatic busPkg::word_t galoisStep(input busPkg::word_t s);
        busPkg::word_t shifted;
        shifted = s >> 1;
        if (s[0]) begin
            shifted = shifted ^ `LFSR_TAPS;
        end
        return shifted;
    endfunction

    function automatic logic [41:0] digitsOf(input busPkg::word_t value);
        logic [41:0] all;
        for (int d = 0; d < 6; d++) begin
            all[d*7 +: 7] = segTable[value[d*4 +: 4]];
        end
        return all;
    endfunction

    // data bus address map
    assign inData = (dAddress >= `DATA_BASE) && (dAddress < `DATA_BASE + 32'd4096);
    assign swHit = (dAddress == `STOPWATCH_ADDR);
    assign lfsrHit = (dAddress == `LFSR_ADDR);
    assign dispHit = (dAddress == `DISPLAY_ADDR);
    assign swNow = busPkg::word_t'((cyc - clearCycle) / 4);

    always_ff @(posedge CLK) begin
        cyc <= cyc + 1;
        dExp <= '0;
        dCheck <= 1'b1;
        swCheck <= 1'b0;
        if (rst) begin
            lfsrShadow <= `LFSR_RESET_SEED;
            dispShadow <= '0;
            clearCycle <= cyc + 1;
            swLast <= '0;
        end else begin
            // data bus read with the answer due next cycle
            if (dReadEnable) begin
                if (inData) begin
                    dExp <= dataShadow[dAddress[11:2]];
                    dCheck <= dataKnown[dAddress[11:2]];
                end else if (swHit) begin
                    dExp <= swNow;
                    swCheck <= 1'b1;
                    swBound <= swLast;
                    swLast <= swNow;
                end else if (lfsrHit) begin
                    dExp <= lfsrShadow;
                end else if (dispHit) begin
                    dExp <= dispShadow;
                end
            end
            // writes land after the old value was captured above
            if (dWriteEnable && inData) begin
                dataShadow[dAddress[11:2]] <= merge(dataShadow[dAddress[11:2]],
                                                    dWriteData, dByteEnable);
                dataKnown[dAddress[11:2]] <= dataKnown[dAddress[11:2]] ||
                                             (dByteEnable == 4'hF);
            end
            if (dWriteEnable && swHit) begin
                clearCycle <= cyc + 1;
                swLast <= '0;
            end
            if (dWriteEnable && dispHit) begin
                dispShadow <= merge(dispShadow, dWriteData, dByteEnable);
            end
            // seed write wins over the advance
            if (dWriteEnable && lfsrHit) begin
                lfsrShadow <= (dWriteData == '0) ? `LFSR_RESET_SEED : dWriteData;
            end else if (dReadEnable && lfsrHit) begin
                lfsrShadow <= galoisStep(lfsrShadow);
            end
        end
        // instruction side aliases on the low index bits
        if (iWriteEnable) begin
            codeShadow[iAddress[11:2]] <= merge(codeShadow[iAddress[11:2]],
                                                iWriteData, iByteEnable);
            codeKnown[iAddress[11:2]] <= codeKnown[iAddress[11:2]] ||
                                         (iByteEnable == 4'hF);
        end
        if (iReadEnable) begin
            iExp <= codeShadow[iAddress[11:2]];
            iCheck <= codeKnown[iAddress[11:2]];
        end
    end

    dataReadBack: assert property (@(posedge CLK) disable iff (rst)
        dCheck |-> dReadData == dExp)
        else begin
            $error("Error dReadData expected %h actual %h", dExp, dReadData);
            failCount = failCount + 1;
        end

    codeFetch: assert property (@(posedge CLK) disable iff (rst)
        iCheck |-> iReadData == iExp)
        else begin
            $error("Error iReadData expected %h actual %h", iExp, iReadData);
            failCount = failCount + 1;
        end

    // count never goes backwards between clears
    stopwatchMonotonic: assert property (@(posedge CLK) disable iff (rst)
        swCheck |-> dReadData >= swBound)
        else begin
            $error("Error dReadData expected at least %h actual %h", swBound, dReadData);
            failCount = failCount + 1;
        end

    hexDigits: assert property (@(posedge CLK) disable iff (rst)
        {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} == digitsOf(dispShadow))
        else begin
            $error("Error HEX5..HEX0 expected %h actual %h", digitsOf(dispShadow),
                   {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0});
            failCount = failCount + 1;
        end

endmodule

// File: tests/deviceBus_tb.sv
`include "bus_defs.svh"

module deviceBus_tb;

    localparam int cycleLimit = 2000;

    logic                CLK;
    logic                rst;
    logic                iReadEnable;
    logic                iWriteEnable;
    busPkg::byteEnable_t iByteEnable;
    busPkg::word_t       iAddress;
    busPkg::word_t       iWriteData;
    busPkg::word_t       iReadData;
    logic                dReadEnable;
    logic                dWriteEnable;
    busPkg::byteEnable_t dByteEnable;
    busPkg::word_t       dAddress;
    busPkg::word_t       dWriteData;
    busPkg::word_t       dReadData;
    busPkg::segments_t   HEX0;
    busPkg::segments_t   HEX1;
    busPkg::segments_t   HEX2;
    busPkg::segments_t   HEX3;
    busPkg::segments_t   HEX4;
    busPkg::segments_t   HEX5;

    logic [31:0] rngState = 32'd13;
    int          cycleCount = 0;
    int          timeouts = 0;

    // short tick so the stopwatch moves within the run
    deviceBus #(
        .TICK_CYCLES(4)
    ) uut (.*);

    bind deviceBus deviceBus_assert checks (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // one of 16 words at the bottom of data memory
    function automatic busPkg::word_t dataAddr(input logic [3:0] slot);
        return `DATA_BASE + {26'b0, slot, 2'b00};
    endfunction

    task automatic busOp(input logic dRe, input logic dWe, input busPkg::byteEnable_t dBe,
                         input busPkg::word_t dAddr, input busPkg::word_t dData,
                         input logic iRe, input logic iWe, input busPkg::byteEnable_t iBe,
                         input busPkg::word_t iAddr, input busPkg::word_t iData);
        @(posedge CLK);
        dReadEnable <= dRe;
        dWriteEnable <= dWe;
        dByteEnable <= dBe;
        dAddress <= dAddr;
        dWriteData <= dData;
        iReadEnable <= iRe;
        iWriteEnable <= iWe;
        iByteEnable <= iBe;
        iAddress <= iAddr;
        iWriteData <= iData;
    endtask

    task automatic dataOp(input logic re, input logic we, input busPkg::byteEnable_t be,
                          input busPkg::word_t addr, input busPkg::word_t data);
        busOp(re, we, be, addr, data, 1'b0, 1'b0, 4'h0, '0, '0);
    endtask

    // write, read, both or idle on the data window
    task automatic randomDataFields(output logic re, output logic we,
                                    output busPkg::byteEnable_t be,
                                    output busPkg::word_t addr, output busPkg::word_t data);
        logic [31:0] r;
        r = nextRand();
        re = (r[1:0] == 2'd1) || (r[1:0] == 2'd2);
        we = (r[1:0] == 2'd0) || (r[1:0] == 2'd2);
        be = r[7:4];
        addr = dataAddr(r[11:8]);
        data = nextRand();
    endtask

    task automatic reportCounts();
        $display("assertion errors: %0d, timeouts: %0d", uut.checks.failCount, timeouts);
    endtask

    initial begin
        logic                re;
        logic                we;
        busPkg::byteEnable_t be;
        busPkg::word_t       addr;
        busPkg::word_t       data;
        logic [31:0]         r;
        rst = 1'b1;
        iReadEnable = 1'b0;
        iWriteEnable = 1'b0;
        iByteEnable = '0;
        iAddress = '0;
        iWriteData = '0;
        dReadEnable = 1'b0;
        dWriteEnable = 1'b0;
        dByteEnable = '0;
        dAddress = '0;
        dWriteData = '0;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        // zero right after reset
        dataOp(1'b0, 1'b0, 4'h0, '0, '0);
        dataOp(1'b0, 1'b0, 4'h0, '0, '0);

        // data memory, fill the window then random traffic
        for (int i = 0; i < 16; i++) begin
            dataOp(1'b0, 1'b1, 4'hF, dataAddr(i[3:0]), nextRand());
        end
        repeat (150) begin
            randomDataFields(re, we, be, addr, data);
            dataOp(re, we, be, addr, data);
        end

        // code memory load, then fetches beside data traffic
        for (int i = 0; i < 16; i++) begin
            busOp(1'b0, 1'b0, 4'h0, '0, '0, 1'b0, 1'b1, 4'hF, {26'b0, i[3:0], 2'b00},
                  nextRand());
        end
        repeat (100) begin
            randomDataFields(re, we, be, addr, data);
            r = nextRand();
            // random upper bits hit the aliases
            busOp(re, we, be, addr, data, r[9] | r[10], r[7:6] == 2'd0, r[15:12],
                  {r[31:12], 6'b0, r[5:2], 2'b00}, nextRand());
        end

        // unmapped reads and idle cycles
        repeat (30) begin
            r = nextRand();
            if (r[0]) begin
                dataOp(1'b1, 1'b0, 4'hF, 32'h2000_0000 + {16'b0, r[15:2], 2'b00}, '0);
            end else begin
                dataOp(1'b0, 1'b0, 4'h0, '0, '0);
            end
        end

        // lfsr from reset seed, from a written seed, after a zero write
        repeat (20) dataOp(1'b1, 1'b0, 4'hF, `LFSR_ADDR, '0);
        dataOp(1'b0, 1'b1, 4'hF, `LFSR_ADDR, nextRand());
        repeat (20) dataOp(1'b1, 1'b0, 4'hF, `LFSR_ADDR, '0);
        dataOp(1'b0, 1'b1, 4'hF, `LFSR_ADDR, '0);
        repeat (10) dataOp(1'b1, 1'b0, 4'hF, `LFSR_ADDR, '0);
        // seed write in the same cycle as a read
        dataOp(1'b1, 1'b1, 4'hF, `LFSR_ADDR, nextRand());
        repeat (5) dataOp(1'b1, 1'b0, 4'hF, `LFSR_ADDR, '0);

        // stopwatch reads at random gaps, occasional clears
        dataOp(1'b0, 1'b1, 4'hF, `STOPWATCH_ADDR, '0);
        repeat (60) begin
            r = nextRand();
            dataOp(r[0], r[5:2] == 4'd0, 4'hF, `STOPWATCH_ADDR, nextRand());
        end

        // display, byte-enabled writes and readback
        repeat (40) begin
            r = nextRand();
            dataOp(r[1:0] != 2'd0, r[1:0] != 2'd1, r[7:4], `DISPLAY_ADDR, nextRand());
        end

        repeat (3) dataOp(1'b0, 1'b0, 4'h0, '0, '0);
        @(posedge CLK);
        reportCounts();
        if (uut.checks.failCount == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            timeouts = timeouts + 1;
            $display("Timeout, stimulus did not finish within %0d cycles", cycleLimit);
            reportCounts();
            $display("Test failed");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+logic
logic/busPkg.sv
logic/wordMemory.sv
logic/dataBusFabric.sv
logic/stopwatchCounter.sv
logic/lfsrGenerator.sv
logic/hexDisplay.sv
logic/deviceBus.sv
tests/deviceBus_assert.sv
tests/deviceBus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= deviceBus_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
ERR_LIMIT ?= 1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1; true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
